/* Makefile */
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module rob_tb \
		--Mdir $(OBJ_DIR) -o rob_sim
	./$(OBJ_DIR)/rob_sim

clean:
	rm -rf $(OBJ_DIR)

/* hw/cdb_arbiter.sv */
//////////////////////////////////////////////////
// two way round robin onto the common data bus
// combinational grant, loser holds its result
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cdb_arbiter
  import cdb_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  cdb_if.sink   alu_res,
  cdb_if.sink   mul_res,
  cdb_if.source bus
);

  // set when the multiplier won the last transfer
  logic     last_mul;
  logic     grant_mul;
  cdb_pkt_t grant_pkt;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  // on a tie the unit not served last wins
  assign grant_mul = mul_res.valid && (!alu_res.valid || !last_mul);

  assign grant_pkt = grant_mul ? mul_res.pkt : alu_res.pkt;

  assign bus.valid = alu_res.valid || mul_res.valid;
  assign bus.pkt   = grant_pkt;

  // only the winner sees bus ready
  assign alu_res.ready = bus.ready && !grant_mul;
  assign mul_res.ready = bus.ready && grant_mul;

  //////////////////////////////////////////////////
  // priority
  //////////////////////////////////////////////////

  // moves only on a completed transfer
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      last_mul <= 1'b0;
    end
    else if (bus.valid && bus.ready)
    begin
      last_mul <= grant_mul;
    end
  end

endmodule

/* hw/cdb_if.sv */
//////////////////////////////////////////////////
// result channel toward the ROB
// valid/ready, packet steady while stalled
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface cdb_if import cdb_pkg::*; ();

  // a result is on offer
  logic     valid;
  // receiver takes it on this edge
  logic     ready;
  cdb_pkt_t pkt;

  //////////////////////////////////////////////////
  // modports
  //////////////////////////////////////////////////

  // driven by a unit, or by the arbiter on the bus side
  modport source (
    output valid,
    output pkt,
    input  ready
  );

  // the arbiter on the unit side, the ROB on the bus side
  modport sink (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

/* hw/cdb_pkg.sv */
//////////////////////////////////////////////////
// packets between the ROB and the two units
// the tag is the ROB entry index of the operation
//////////////////////////////////////////////////

`include "rob_consts.svh"

package cdb_pkg;

  import rob_pkg::*;

  //////////////////////////////////////////////////
  // issue packet, ROB to execution unit
  //////////////////////////////////////////////////

  // operands travel as values, no register read
  typedef struct packed {
    logic [`TAG_W-1:0]   tag;
    rob_op_t             op;
    logic [`VALUE_W-1:0] a;
    logic [`VALUE_W-1:0] b;
  } issue_pkt_t;

  //////////////////////////////////////////////////
  // result packet on the common data bus
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [`TAG_W-1:0]   tag;
    logic [`VALUE_W-1:0] value;
  } cdb_pkt_t;

endpackage

/* hw/exec_unit.sv */
//////////////////////////////////////////////////
// pipelined execution unit, DEPTH stages
// result valid DEPTH cycles after issue
// stalls stage by stage when the bus refuses
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_consts.svh"

module exec_unit
  import rob_pkg::*, cdb_pkg::*;
#(
  parameter int DEPTH = 1
)
(
  input  logic      clock,
  input  logic      reset,
  issue_if.unit_side issue,
  cdb_if.source     result
);

  // one valid and one packet per stage, stage 0 is the first
  logic [DEPTH-1:0]    stage_valid;
  cdb_pkt_t            stage_pkt [DEPTH];
  // stage may take new contents this edge
  logic [DEPTH-1:0]    can_load;
  logic [`VALUE_W-1:0] op_result;

  //////////////////////////////////////////////////
  // first stage arithmetic
  //////////////////////////////////////////////////

  always_comb
  begin
    case (issue.pkt.op)
      OP_ADD:  op_result = issue.pkt.a + issue.pkt.b;
      OP_SUB:  op_result = issue.pkt.a - issue.pkt.b;
      OP_XOR:  op_result = issue.pkt.a ^ issue.pkt.b;
      // low half of the product only
      default: op_result = issue.pkt.a * issue.pkt.b;
    endcase
  end

  //////////////////////////////////////////////////
  // stall chain
  //////////////////////////////////////////////////

  // a stage loads when it is empty or its contents move on
  always_comb
  begin
    can_load[DEPTH-1] = !stage_valid[DEPTH-1] || result.ready;
    for (int i = DEPTH - 2; i >= 0; i--)
    begin
      can_load[i] = !stage_valid[i] || can_load[i+1];
    end
  end

  assign issue.ready  = can_load[0];
  assign result.valid = stage_valid[DEPTH-1];
  assign result.pkt   = stage_pkt[DEPTH-1];

  // valid bits
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      stage_valid <= '0;
    end
    else
    begin
      if (can_load[0])
        stage_valid[0] <= issue.valid;
      for (int i = 1; i < DEPTH; i++)
      begin
        if (can_load[i])
          stage_valid[i] <= stage_valid[i-1];
      end
    end
  end

  // payload moves with its valid bit
  always_ff @(posedge clock)
  begin
    if (can_load[0])
      stage_pkt[0] <= '{tag: issue.pkt.tag, value: op_result};
    for (int i = 1; i < DEPTH; i++)
    begin
      if (can_load[i])
        stage_pkt[i] <= stage_pkt[i-1];
    end
  end

endmodule

/* hw/issue_if.sv */
//////////////////////////////////////////////////
// issue channel, ROB to one execution unit
// valid/ready, packet steady while stalled
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface issue_if import cdb_pkg::*; ();

  // high while the ROB offers an operation
  logic       valid;
  // unit can take an operation this cycle
  logic       ready;
  issue_pkt_t pkt;

  // ROB end of the channel
  modport rob_side (
    output valid,
    output pkt,
    input  ready
  );

  // execution unit end
  modport unit_side (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

/* hw/rob.sv */
//////////////////////////////////////////////////
// 32 entry reorder buffer, in order commit
// one dispatch, one completion, one commit per cycle
// the bus is always accepted, no flush
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_consts.svh"

module rob
  import rob_pkg::*, cdb_pkg::*;
(
  input  logic                clock,
  input  logic                reset,

  // dispatch side
  input  logic                dispatch_valid,
  output logic                dispatch_ready,
  input  rob_op_t             dispatch_op,
  input  logic [`REG_W-1:0]   dispatch_dest,
  input  logic [`VALUE_W-1:0] dispatch_a,
  input  logic [`VALUE_W-1:0] dispatch_b,

  // issue toward the two units
  issue_if.rob_side           alu_issue,
  issue_if.rob_side           mul_issue,

  // completions from the arbiter
  cdb_if.sink                 bus,

  // commit side
  output logic                commit_valid,
  input  logic                commit_ready,
  output logic [`REG_W-1:0]   commit_dest,
  output logic [`VALUE_W-1:0] commit_value
);

  //////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////

  rob_entry_t          entries [`ROB_ENTRIES];
  // head is the oldest entry, tail the next free one
  logic [`TAG_W-1:0]   head;
  logic [`TAG_W-1:0]   tail;
  // occupancy, one bit wider to hold the full count
  logic [`TAG_W:0]     count;

  logic                full;
  logic                is_mul;
  logic                unit_ready;
  logic                alloc;
  logic                retire;
  issue_pkt_t          issue_pkt;

  //////////////////////////////////////////////////
  // dispatch and issue steering
  //////////////////////////////////////////////////

  assign full = (count == `ROB_ENTRIES);

  // only the multiply goes to the pipelined unit
  assign is_mul = (dispatch_op == OP_MUL);

  // ready of the target unit, never a function of issue valid
  assign unit_ready = is_mul ? mul_issue.ready : alu_issue.ready;

  assign dispatch_ready = !full && unit_ready;
  assign alloc          = dispatch_valid && dispatch_ready;

  // tag is the entry about to be written at the tail
  assign issue_pkt = '{tag: tail, op: dispatch_op, a: dispatch_a, b: dispatch_b};

  // both units see the same packet, valid picks one
  assign alu_issue.pkt   = issue_pkt;
  assign mul_issue.pkt   = issue_pkt;
  // gated by full so a unit never takes an op that gets no entry
  assign alu_issue.valid = dispatch_valid && !full && !is_mul;
  assign mul_issue.valid = dispatch_valid && !full && is_mul;

  // the bus never stalls at the ROB
  assign bus.ready = 1'b1;

  //////////////////////////////////////////////////
  // commit
  //////////////////////////////////////////////////

  assign commit_valid = entries[head].valid && entries[head].complete;
  assign commit_dest  = entries[head].dest;
  assign commit_value = entries[head].value;
  assign retire       = commit_valid && commit_ready;

  //////////////////////////////////////////////////
  // state update
  //////////////////////////////////////////////////

  // retire, completion and allocation touch different entries:
  // alloc needs a free tail, completion hits an incomplete entry,
  // retire hits the complete head
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < `ROB_ENTRIES; i++)
      begin
        entries[i].valid    <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end
    else
    begin
      // in order retirement from the head
      if (retire)
      begin
        entries[head].valid    <= 1'b0;
        entries[head].complete <= 1'b0;
        head                   <= head + 1'b1;
      end
      // out of order completion by tag
      if (bus.valid)
      begin
        entries[bus.pkt.tag].complete <= 1'b1;
        entries[bus.pkt.tag].value    <= bus.pkt.value;
      end
      // allocation at the tail
      if (alloc)
      begin
        entries[tail].valid    <= 1'b1;
        entries[tail].complete <= 1'b0;
        entries[tail].dest     <= dispatch_dest;
        tail                   <= tail + 1'b1;
      end
      case ({alloc, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hw/rob_consts.svh */
//////////////////////////////////////////////////
// sizes and widths for the ROB engine
// ROB_ENTRIES must be a power of two, 2**TAG_W
// so that head and tail wrap by overflow
//////////////////////////////////////////////////

`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer depth
`define ROB_ENTRIES 32

// entry index, also the tag carried by issue and result packets
`define TAG_W 5

// architectural destination register number
`define REG_W 5

// operands and results
`define VALUE_W 64

// stages in the multiplier pipeline, result valid this many cycles after issue
`define MUL_DEPTH 3

`endif

/* hw/rob_pkg.sv */
//////////////////////////////////////////////////
// ROB side types: operation code and entry
// the entry keeps no instruction word
//////////////////////////////////////////////////

`include "rob_consts.svh"

package rob_pkg;

  //////////////////////////////////////////////////
  // operation code
  //////////////////////////////////////////////////

  // add, sub and xor run on the ALU, mul on the multiplier
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MUL = 2'd3
  } rob_op_t;

  //////////////////////////////////////////////////
  // reorder buffer entry
  //////////////////////////////////////////////////

  // valid: allocated and not yet retired
  // complete: result has come back on the bus
  typedef struct packed {
    logic                valid;
    logic                complete;
    logic [`REG_W-1:0]   dest;
    logic [`VALUE_W-1:0] value;
  } rob_entry_t;

endpackage

/* hw/rob_top.sv */
//////////////////////////////////////////////////
// ROB engine top, plain valid/ready ports
// ALU one cycle, multiplier MUL_DEPTH cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic                clock,
  input  logic                reset,

  // dispatch, in program order
  input  logic                dispatch_valid,
  output logic                dispatch_ready,
  input  rob_op_t             dispatch_op,
  input  logic [`REG_W-1:0]   dispatch_dest,
  input  logic [`VALUE_W-1:0] dispatch_a,
  input  logic [`VALUE_W-1:0] dispatch_b,

  // commit, in program order
  output logic                commit_valid,
  input  logic                commit_ready,
  output logic [`REG_W-1:0]   commit_dest,
  output logic [`VALUE_W-1:0] commit_value
);

  // issue channels, one per unit
  issue_if alu_issue ();
  issue_if mul_issue ();

  // unit results and the shared bus
  cdb_if   alu_res ();
  cdb_if   mul_res ();
  cdb_if   bus ();

  rob i_rob (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_op    (dispatch_op),
    .dispatch_dest  (dispatch_dest),
    .dispatch_a     (dispatch_a),
    .dispatch_b     (dispatch_b),
    .alu_issue      (alu_issue),
    .mul_issue      (mul_issue),
    .bus            (bus),
    .commit_valid   (commit_valid),
    .commit_ready   (commit_ready),
    .commit_dest    (commit_dest),
    .commit_value   (commit_value)
  );

  exec_unit #(.DEPTH(1)) i_alu (
    .clock  (clock),
    .reset  (reset),
    .issue  (alu_issue),
    .result (alu_res)
  );

  exec_unit #(.DEPTH(`MUL_DEPTH)) i_mul (
    .clock  (clock),
    .reset  (reset),
    .issue  (mul_issue),
    .result (mul_res)
  );

  cdb_arbiter i_arb (
    .clock   (clock),
    .reset   (reset),
    .alu_res (alu_res),
    .mul_res (mul_res),
    .bus     (bus)
  );

endmodule

/* project.f */
+incdir+hw
hw/rob_pkg.sv
hw/cdb_pkg.sv
hw/issue_if.sv
hw/cdb_if.sv
hw/rob.sv
hw/exec_unit.sv
hw/cdb_arbiter.sv
hw/rob_top.sv
tests/rob_props.sv
tests/rob_tb.sv

/* tests/rob_props.sv */
//////////////////////////////////////////////////
// handshake properties of the ROB engine top
// bound to rob_top, sampled on the rising clock
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_props (
  input logic                clock,
  input logic                reset,
  input logic                dispatch_ready,
  input logic                commit_valid,
  input logic                commit_ready,
  input logic [`REG_W-1:0]   commit_dest,
  input logic [`VALUE_W-1:0] commit_value
);

  // an offered commit stays up and steady until taken
  commit_hold: assert property (@(posedge clock) disable iff (reset)
    commit_valid && !commit_ready |=>
      commit_valid && $stable(commit_dest) && $stable(commit_value))
    else $error("commit offer dropped or changed before commit_ready");

  // empty ROB out of reset, nothing to commit
  commit_idle_after_reset: assert property (@(posedge clock) reset |=> !commit_valid)
    else $error("commit_valid high after reset");

  // empty ROB and idle units accept at once
  dispatch_open_after_reset: assert property (@(posedge clock) reset |=> dispatch_ready)
    else $error("dispatch_ready low after reset");

endmodule

bind rob_top rob_props i_props (
  .clock          (clock),
  .reset          (reset),
  .dispatch_ready (dispatch_ready),
  .commit_valid   (commit_valid),
  .commit_ready   (commit_ready),
  .commit_dest    (commit_dest),
  .commit_value   (commit_value)
);

/* tests/rob_tb.sv */
//////////////////////////////////////////////////
// testbench for the ROB engine top
// random ops from a fixed seed
// commits checked in program order
// stops at the first error
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_tb
  import rob_pkg::*;
();

  localparam int WAIT_LIMIT   = 200;
  localparam int RANDOM_OPS   = 300;
  // commit_ready modes
  localparam int READY_RANDOM = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_HIGH   = 2;

  logic                clock = 1'b0;
  logic                reset;
  logic                dispatch_valid;
  logic                dispatch_ready;
  rob_op_t             dispatch_op;
  logic [`REG_W-1:0]   dispatch_dest;
  logic [`VALUE_W-1:0] dispatch_a;
  logic [`VALUE_W-1:0] dispatch_b;
  logic                commit_valid;
  logic                commit_ready;
  logic [`REG_W-1:0]   commit_dest;
  logic [`VALUE_W-1:0] commit_value;

  int                  seed = 32'h60e3;
  int                  dispatched = 0;
  int                  committed = 0;
  int                  waited;
  // expected commits with the oldest at the front
  logic [`REG_W-1:0]   exp_dest_q [$];
  logic [`VALUE_W-1:0] exp_value_q [$];
  logic [`REG_W-1:0]   want_dest;
  logic [`VALUE_W-1:0] want_value;

  rob_top i_dut (.*);

  always #2 clock = ~clock;

  //////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////

  // mul keeps the low half of the full product
  function automatic logic [`VALUE_W-1:0] expected_result(input rob_op_t op,
      input logic [`VALUE_W-1:0] a, input logic [`VALUE_W-1:0] b);
    logic [2*`VALUE_W-1:0] product;
    product = {{`VALUE_W{1'b0}}, a} * {{`VALUE_W{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return product[`VALUE_W-1:0];
    endcase
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic drive_commit(input int mode);
    int rnd;
    rnd = $random(seed);
    case (mode)
      READY_LOW:  commit_ready <= 1'b0;
      READY_HIGH: commit_ready <= 1'b1;
      default:    commit_ready <= rnd[0];
    endcase
  endtask

  // offer one op until accepted and then record what it must commit
  task automatic dispatch_one(input rob_op_t op, input logic [`REG_W-1:0] dest,
      input logic [`VALUE_W-1:0] a, input logic [`VALUE_W-1:0] b,
      input int mode, output int edges);
    logic taken;
    edges = 0;
    dispatch_valid <= 1'b1;
    dispatch_op    <= op;
    dispatch_dest  <= dest;
    dispatch_a     <= a;
    dispatch_b     <= b;
    do
    begin
      @(posedge clock);
      taken = dispatch_ready;
      drive_commit(mode);
      edges++;
      if (!taken && edges >= WAIT_LIMIT)
        stop_on_error("a dispatch was not accepted within the wait limit");
    end while (!taken);
    exp_dest_q.push_back(dest);
    exp_value_q.push_back(expected_result(op, a, b));
    dispatched++;
  endtask

  task automatic dispatch_random(input int mode);
    int      rnd;
    int      edges;
    rob_op_t op;
    rnd = $random(seed);
    op  = rob_op_t'(rnd[1:0]);
    dispatch_one(op, rnd[6:2], {$random(seed), $random(seed)},
                 {$random(seed), $random(seed)}, mode, edges);
  endtask

  // run until every dispatched op has committed
  task automatic wait_drained(input int mode);
    int edges;
    edges = 0;
    while (committed != dispatched)
    begin
      @(posedge clock);
      drive_commit(mode);
      edges++;
      if (committed != dispatched && edges >= WAIT_LIMIT)
        stop_on_error("outstanding ops did not commit within the wait limit");
    end
  endtask

  //////////////////////////////////////////////////
  // commit checker
  //////////////////////////////////////////////////

  always @(posedge clock)
  begin
    if (!reset && commit_valid && commit_ready)
    begin
      assert (exp_dest_q.size() > 0)
      else
        stop_on_error("a commit came out with no dispatch outstanding");
      want_dest  = exp_dest_q.pop_front();
      want_value = exp_value_q.pop_front();
      assert (commit_dest === want_dest)
      else
        stop_on_error($sformatf("mismatch commit_dest got %h expected %h",
                                commit_dest, want_dest));
      assert (commit_value === want_value)
      else
        stop_on_error($sformatf("mismatch commit_value got %h expected %h",
                                commit_value, want_value));
      committed <= committed + 1;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    reset          <= 1'b1;
    dispatch_valid <= 1'b0;
    dispatch_op    <= OP_ADD;
    dispatch_dest  <= '0;
    dispatch_a     <= '0;
    dispatch_b     <= '0;
    commit_ready   <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    assert (!commit_valid)
    else
      stop_on_error("commit_valid is high in the first cycle after reset");
    assert (dispatch_ready)
    else
      stop_on_error("dispatch_ready is low in the first cycle after reset");

    // short ALU ops right behind a multiply finish first but commit later
    dispatch_one(OP_MUL, 5'd1, 64'h0123_4567_89ab_cdef, 64'h1003, READY_HIGH, waited);
    dispatch_one(OP_ADD, 5'd2, 64'hffff_ffff_ffff_fff0, 64'h20, READY_HIGH, waited);
    dispatch_one(OP_SUB, 5'd3, 64'h5, 64'h9, READY_HIGH, waited);
    dispatch_one(OP_XOR, 5'd4, 64'haaaa_5555_aaaa_5555, 64'hffff, READY_HIGH, waited);
    dispatch_one(OP_MUL, 5'd5, 64'hffff_ffff_ffff_ffff, 64'h3, READY_HIGH, waited);
    dispatch_one(OP_ADD, 5'd6, 64'h1, 64'h2, READY_HIGH, waited);
    dispatch_valid <= 1'b0;
    wait_drained(READY_HIGH);

    // random mix with commit back-pressure so results collide on the bus
    for (int i = 0; i < RANDOM_OPS; i++)
      dispatch_random(READY_RANDOM);
    dispatch_valid <= 1'b0;
    wait_drained(READY_HIGH);

    // with commits held back the ROB takes exactly ROB_ENTRIES ops
    for (int i = 0; i < `ROB_ENTRIES; i++)
      dispatch_random(READY_LOW);
    dispatch_op   <= OP_ADD;
    dispatch_dest <= 5'd7;
    dispatch_a    <= 64'h11;
    dispatch_b    <= 64'h22;
    repeat (8)
    begin
      @(posedge clock);
      assert (!dispatch_ready)
      else
        stop_on_error("dispatch_ready stayed high with the ROB full");
    end
    waited = 0;
    do
    begin
      @(posedge clock);
      waited++;
      if (!commit_valid && waited >= WAIT_LIMIT)
        stop_on_error("the head entry never completed while the ROB was full");
    end while (!commit_valid);
    // release exactly one commit
    commit_ready <= 1'b1;
    @(posedge clock);
    commit_ready <= 1'b0;
    dispatch_one(OP_ADD, 5'd7, 64'h11, 64'h22, READY_LOW, waited);
    assert (waited == 1)
    else
      stop_on_error("dispatch_ready did not rise in the cycle after one commit");
    dispatch_valid <= 1'b0;
    wait_drained(READY_HIGH);

    $display("Everything OK");
    $finish;
  end

endmodule
